/* verification/uart_cmd_patterns.txt */
// cmd  mode  rsp.data  rsp.parity_err  rsp.timeout
// mode: 0 normal, 1 bad_parity, 2 silent; rsp fields unused for writes
853C 0 00 0 0
0500 0 3C 0 0
1000 0 B5 0 0
FF81 0 00 0 0
7F00 0 81 0 0
2200 1 87 1 0
3300 2 00 0 1
8000 0 00 0 0
0000 0 00 0 0
01FF 0 A4 0 0
C0FF 0 00 0 0
4000 1 FF 1 0
4000 0 FF 0 0
85A5 0 00 0 0
05A5 0 A5 0 0
6E00 2 00 0 1
6E00 0 CB 0 0
AA55 0 00 0 0
2A00 0 55 0 0
1500 0 B0 0 0
9501 0 00 0 0
1500 0 01 0 0
7E00 0 DB 0 0

/* list.f */
rtl/uart_cfg_pkg.sv
rtl/uart_cmd_pkg.sv
rtl/uart_tx_frame.sv
rtl/uart_rx_frame.sv
rtl/uart_cmd_master.sv
rtl/uart_cmd_top.sv
verification/uart_cmd_checker.sv
verification/tb_uart_cmd.sv

/* verification/tb_uart_cmd.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd;

  import uart_cfg_pkg::*;
  import uart_cmd_pkg::*;

  localparam int          clk_period      = 4;
  localparam int          max_pats        = 64;
  localparam int          pat_fields      = 5;
  localparam int          mode_normal     = 0;
  localparam int          mode_bad_parity = 1;
  localparam int          mode_silent     = 2;
  localparam logic [31:0] lfsr_seed       = 32'h042658b7;

  logic        clk;
  logic        rst_n;
  cmd_word_u   cmd;
  logic        cmd_vld;
  logic        cmd_rdy;
  rsp_t        rsp;
  logic        rsp_vld;
  logic        tx;
  logic        rx;
  logic [15:0] pat_mem [0:max_pats*pat_fields-1];
  logic [7:0]  regs [0:127];
  int          reply_q[$];
  int          n_pats;
  int          n_reads;
  logic [31:0] lfsr;

  uart_cmd_top dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .rsp     (rsp),
    .rsp_vld (rsp_vld),
    .tx      (tx),
    .rx      (rx)
  );

  uart_cmd_checker chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .rsp     (rsp),
    .rsp_vld (rsp_vld),
    .tx      (tx)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(clk_period / 2) clk = ~clk;
    end
  end

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // ************************************************************
  // Peripheral model
  // ************************************************************

  // Samples tx at mid-bit on falling edges, returns at mid stop bit.
  task automatic read_frame(output logic [7:0] b);
    int i;
    @(negedge tx);
    repeat (half_bit) @(negedge clk);
    for (i = 0; i < data_bits; i++)
    begin
      repeat (clks_per_bit) @(negedge clk);
      b[i] = tx;
    end
    repeat (2 * clks_per_bit) @(negedge clk);
  endtask

  task automatic send_frame(input logic [7:0] b, input logic bad_par);
    logic [frame_bits-1:0] bits;
    int                    i;
    bits = {1'b1, (~^b) ^ bad_par, b, 1'b0};
    for (i = 0; i < frame_bits; i++)
    begin
      rx = bits[i];
      repeat (clks_per_bit) @(negedge clk);
    end
  endtask

  initial
  begin : peripheral
    logic [7:0] addr_b;
    logic [7:0] data_b;
    int         mode;
    int         a;
    for (a = 0; a < 128; a++)
    begin
      regs[a] = 8'(a) ^ 8'hA5;
    end
    forever
    begin
      read_frame(addr_b);
      if (addr_b[7])
      begin
        read_frame(data_b);
        regs[addr_b[6:0]] = data_b;
      end
      else
      begin
        mode = (reply_q.size() != 0) ? reply_q.pop_front() : mode_normal;
        repeat (frame_gap) @(negedge clk);
        if (mode != mode_silent)
        begin
          send_frame(regs[addr_b[6:0]], mode == mode_bad_parity);
        end
      end
    end
  end

  // ************************************************************
  // Command stimulus
  // ************************************************************

  initial
  begin : stimulus
    cmd_word_u word;
    rsp_t      exp_rsp;
    int        base;
    int        gap;
    int        p;
    int        k;
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    lfsr    = lfsr_seed;
    n_reads = 0;
    n_pats  = 0;
    $readmemh("verification/uart_cmd_patterns.txt", pat_mem);
    while (n_pats < max_pats && !$isunknown(pat_mem[n_pats * pat_fields]))
    begin
      n_pats++;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (p = 0; p < n_pats; p++)
    begin
      base = p * pat_fields;
      gap  = 0;
      for (k = 0; k < 4; k++)
      begin
        lfsr = lfsr_next(lfsr);
        gap  = (gap << 1) | lfsr[0];
      end
      repeat (gap) @(negedge clk);
      word = pat_mem[base];
      chk.push_tx({word.rd.is_wr, word.rd.addr});
      if (word.wr.is_wr)
      begin
        chk.push_tx(word.wr.data);
      end
      else
      begin
        exp_rsp.data       = pat_mem[base + 2][7:0];
        exp_rsp.parity_err = pat_mem[base + 3][0];
        exp_rsp.timeout    = pat_mem[base + 4][0];
        chk.push_rsp(exp_rsp);
        reply_q.push_back(int'(pat_mem[base + 1]));
        n_reads++;
      end
      // Held until a rising edge sees cmd_rdy high.
      cmd     = word;
      cmd_vld = 1'b1;
      while (!cmd_rdy)
      begin
        @(negedge clk);
      end
      @(negedge clk);
      cmd_vld = 1'b0;
    end
    while (!cmd_rdy)
    begin
      @(negedge clk);
    end
    repeat (10) @(negedge clk);
    chk.final_check(n_pats);
    $display("Done: %0d commands, %0d reads, %0d frames, %0d responses, %0d errors",
             n_pats, n_reads, chk.frames, chk.rsps, chk.errors);
    if (chk.errors == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial
  begin : watchdog
    longint limit;
    #1;
    limit = (longint'(n_pats) * (3 * frame_bits * clks_per_bit + 2 * frame_gap + rsp_timeout)
             + 50) * clk_period * 2;
    #(limit);
    $display("Timeout: the run did not finish within %0d ns", limit);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/uart_cmd_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_checker (
  input logic               clk,
  input logic               rst_n,
  input logic               cmd_vld,
  input logic               cmd_rdy,
  input uart_cmd_pkg::rsp_t rsp,
  input logic               rsp_vld,
  input logic               tx
);

  import uart_cfg_pkg::*;
  import uart_cmd_pkg::*;

  int         errors   = 0;
  int         accepts  = 0;
  int         frames   = 0;
  int         rsps     = 0;
  logic       accepted = 1'b0;
  logic [7:0] exp_tx_q[$];
  rsp_t       exp_rsp_q[$];

  task automatic push_tx(input logic [7:0] b);
    exp_tx_q.push_back(b);
  endtask

  task automatic push_rsp(input rsp_t r);
    exp_rsp_q.push_back(r);
  endtask

  task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
    begin
      errors++;
      $display("Error at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Failure at %0t: %s", $time, what);
  endtask

  // ************************************************************
  // Serial frame decoding
  // ************************************************************

  // Called on the first sampled cycle of a start bit.
  task automatic decode_frame();
    logic [frame_bits-1:0] bits;
    int                    unstable;
    int                    i;
    int                    c;
    unstable = 0;
    for (i = 0; i < frame_bits; i++)
    begin
      for (c = 0; c < clks_per_bit; c++)
      begin
        if (i != 0 || c != 0)
        begin
          @(posedge clk);
        end
        if (c == 0)
        begin
          bits[i] = tx;
        end
        else if (tx !== bits[i])
        begin
          unstable++;
        end
      end
    end
    frames++;
    compare("tx start bit", 8'h00, bits[0]);
    // Data plus parity must hold an odd number of ones.
    compare("tx parity bit", 8'h01, ^bits[9:1]);
    compare("tx stop bit", 8'h01, bits[frame_bits-1]);
    if (unstable != 0)
    begin
      report_failure("a tx bit changed before its bit period ended");
    end
    if (exp_tx_q.size() == 0)
    begin
      report_failure("tx frame sent with no byte expected");
    end
    else
    begin
      compare("tx byte", exp_tx_q.pop_front(), bits[8:1]);
    end
  endtask

  initial
  begin
    forever
    begin
      @(posedge clk);
      if (rst_n === 1'b1 && tx === 1'b0)
      begin
        decode_frame();
      end
    end
  end

  // ************************************************************
  // Host ports
  // ************************************************************

  task automatic check_rsp();
    rsp_t exp;
    rsps++;
    if (cmd_rdy !== 1'b1)
    begin
      report_failure("cmd_rdy not high together with rsp_vld");
    end
    if (exp_rsp_q.size() == 0)
    begin
      report_failure("rsp_vld pulsed with no read pending");
    end
    else
    begin
      exp = exp_rsp_q.pop_front();
      compare("rsp.data", exp.data, rsp.data);
      compare("rsp.parity_err", exp.parity_err, rsp.parity_err);
      compare("rsp.timeout", exp.timeout, rsp.timeout);
    end
  endtask

  always @(posedge clk)
  begin
    if (rst_n === 1'b1)
    begin
      if (accepted && cmd_rdy !== 1'b0)
      begin
        report_failure("cmd_rdy stayed high the cycle after a command was accepted");
      end
      accepted = (cmd_vld === 1'b1 && cmd_rdy === 1'b1);
      if (accepted)
      begin
        accepts++;
      end
      if (rsp_vld === 1'b1)
      begin
        check_rsp();
      end
    end
  end

  task automatic final_check(input int n_cmds);
    if (n_cmds == 0)
    begin
      report_failure("pattern file gave no commands");
    end
    if (accepts != n_cmds)
    begin
      report_failure($sformatf("%0d commands accepted, %0d issued", accepts, n_cmds));
    end
    if (exp_tx_q.size() != 0)
    begin
      report_failure("expected tx frames were never sent");
    end
    if (exp_rsp_q.size() != 0)
    begin
      report_failure("expected responses never arrived");
    end
  endtask

endmodule

`default_nettype wire

/* rtl/uart_cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::cmd_word_u cmd,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  output uart_cmd_pkg::rsp_t      rsp,
  output logic                    rsp_vld,
  output logic                    tx,
  input  logic                    rx
);

  import uart_cmd_pkg::*;

  logic [7:0]  tx_byte;
  logic        tx_vld;
  logic        tx_rdy;
  frame_byte_t rx_frame;
  logic        rx_vld;

  uart_cmd_master u_master (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx_byte  (tx_byte),
    .tx_vld   (tx_vld),
    .tx_rdy   (tx_rdy),
    .rx_frame (rx_frame),
    .rx_vld   (rx_vld),
    .rsp      (rsp),
    .rsp_vld  (rsp_vld)
  );

  uart_tx_frame u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_byte (tx_byte),
    .tx_vld  (tx_vld),
    .tx_rdy  (tx_rdy),
    .tx      (tx)
  );

  uart_rx_frame u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_frame (rx_frame),
    .rx_vld   (rx_vld)
  );

endmodule

`default_nettype wire

/* rtl/uart_cmd_master.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_master (
  input  logic                      clk,
  input  logic                      rst_n,
  input  uart_cmd_pkg::cmd_word_u   cmd,
  input  logic                      cmd_vld,
  output logic                      cmd_rdy,
  output logic [7:0]                tx_byte,
  output logic                      tx_vld,
  input  logic                      tx_rdy,
  input  uart_cmd_pkg::frame_byte_t rx_frame,
  input  logic                      rx_vld,
  output uart_cmd_pkg::rsp_t        rsp,
  output logic                      rsp_vld
);

  import uart_cfg_pkg::*;
  import uart_cmd_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_addr,
    st_addr_wait,
    st_gap,
    st_data,
    st_data_wait,
    st_rsp
  } state_t;

  state_t                state_q;
  cmd_word_u             cmd_q;
  logic [wait_cnt_w-1:0] cnt_q;
  logic                  cmd_acc;
  logic                  tx_acc;
  logic                  gap_done;
  logic                  rsp_hit;
  logic                  rsp_tmo;

  assign cmd_rdy = (state_q == st_idle);
  assign cmd_acc = cmd_vld & cmd_rdy;
  assign tx_vld  = (state_q == st_addr) || (state_q == st_data);
  assign tx_acc  = tx_vld & tx_rdy;

  // Address byte carries the write flag in its top bit.
  assign tx_byte = (state_q == st_data) ? cmd_q.wr.data : {cmd_q.rd.is_wr, cmd_q.rd.addr};

  assign gap_done = (state_q == st_gap) && (cnt_q == wait_cnt_w'(frame_gap - 1));
  assign rsp_hit  = (state_q == st_rsp) && rx_vld;
  assign rsp_tmo  = (state_q == st_rsp) && !rx_vld
                    && (cnt_q == wait_cnt_w'(rsp_timeout - 1));

  // ************************************************************
  // Command FSM
  // ************************************************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= st_idle;
      cnt_q   <= '0;
      rsp_vld <= 1'b0;
    end
    else
    begin
      rsp_vld <= 1'b0;
      case (state_q)
        st_idle:
          if (cmd_acc)
          begin
            state_q <= st_addr;
          end
        st_addr:
          if (tx_acc)
          begin
            state_q <= st_addr_wait;
          end
        st_addr_wait:
          if (tx_rdy)
          begin
            state_q <= st_gap;
            cnt_q   <= '0;
          end
        st_gap:
          if (gap_done)
          begin
            cnt_q   <= '0;
            state_q <= cmd_q.wr.is_wr ? st_data : st_rsp;
          end
          else
          begin
            cnt_q <= cnt_q + 1'b1;
          end
        st_data:
          if (tx_acc)
          begin
            state_q <= st_data_wait;
          end
        st_data_wait:
          if (tx_rdy)
          begin
            state_q <= st_idle;
          end
        st_rsp:
          if (rsp_hit || rsp_tmo)
          begin
            rsp_vld <= 1'b1;
            state_q <= st_idle;
          end
          else
          begin
            cnt_q <= cnt_q + 1'b1;
          end
        default:
          state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_acc)
    begin
      cmd_q <= cmd;
    end
  end

  // A broken stop bit is reported as a parity error.
  always_ff @(posedge clk)
  begin
    if (rsp_hit)
    begin
      rsp.data       <= rx_frame.data;
      rsp.parity_err <= rx_frame.parity_err | rx_frame.frame_err;
      rsp.timeout    <= 1'b0;
    end
    else if (rsp_tmo)
    begin
      rsp.data       <= '0;
      rsp.parity_err <= 1'b0;
      rsp.timeout    <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/uart_rx_frame.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_frame (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      rx,
  output uart_cmd_pkg::frame_byte_t rx_frame,
  output logic                      rx_vld
);

  import uart_cfg_pkg::*;

  logic [1:0]            sync_q;
  logic                  rx_d_q;
  logic                  rx_s;
  logic                  fall;
  logic                  busy_q;
  logic [baud_cnt_w-1:0] baud_cnt_q;
  logic [bit_cnt_w-1:0]  bit_cnt_q;
  logic [data_bits-1:0]  data_q;
  logic                  par_err_q;
  logic                  sample;
  logic                  at_start;
  logic                  at_data;
  logic                  at_par;
  logic                  at_stop;

  assign rx_s = sync_q[1];
  assign fall = rx_d_q & ~rx_s;

  // Baud counter runs down; zero is the mid-bit sample.
  assign sample   = busy_q && (baud_cnt_q == '0);
  assign at_start = (bit_cnt_q == '0);
  assign at_data  = !at_start && (bit_cnt_q <= bit_cnt_w'(data_bits));
  assign at_par   = (bit_cnt_q == bit_cnt_w'(data_bits + 1));
  assign at_stop  = (bit_cnt_q == bit_cnt_w'(frame_bits - 1));

  // Two-flop synchronizer, then one more flop for the edge.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_q <= 2'b11;
      rx_d_q <= 1'b1;
    end
    else
    begin
      sync_q <= {sync_q[0], rx};
      rx_d_q <= rx_s;
    end
  end

  // ************************************************************
  // Frame sequencing
  // ************************************************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q     <= 1'b0;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      rx_vld     <= 1'b0;
    end
    else
    begin
      rx_vld <= 1'b0;
      if (!busy_q)
      begin
        if (fall)
        begin
          busy_q     <= 1'b1;
          baud_cnt_q <= baud_cnt_w'(half_bit - 1);
          bit_cnt_q  <= '0;
        end
      end
      else if (baud_cnt_q != '0)
      begin
        baud_cnt_q <= baud_cnt_q - 1'b1;
      end
      else
      begin
        baud_cnt_q <= baud_cnt_w'(clks_per_bit - 1);
        bit_cnt_q  <= bit_cnt_q + 1'b1;
        // Glitch, not a start bit.
        if (at_start && rx_s)
        begin
          busy_q <= 1'b0;
        end
        if (at_stop)
        begin
          busy_q <= 1'b0;
          rx_vld <= 1'b1;
        end
      end
    end
  end

  // Data arrives LSB first.
  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (at_data)
      begin
        data_q <= {rx_s, data_q[data_bits-1:1]};
      end
      if (at_par)
      begin
        par_err_q <= ~^{data_q, rx_s};
      end
      if (at_stop)
      begin
        rx_frame.data       <= data_q;
        rx_frame.parity_err <= par_err_q;
        rx_frame.frame_err  <= ~rx_s;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/uart_tx_frame.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_frame (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] tx_byte,
  input  logic       tx_vld,
  output logic       tx_rdy,
  output logic       tx
);

  import uart_cfg_pkg::*;

  logic                  busy_q;
  logic [baud_cnt_w-1:0] baud_cnt_q;
  logic [bit_cnt_w-1:0]  bit_cnt_q;
  // Stop, parity and data bits still to go, next one in bit 0.
  logic [data_bits+1:0]  shift_q;
  logic                  tx_acc;
  logic                  bit_end;

  assign tx_rdy  = ~busy_q;
  assign tx_acc  = tx_vld & ~busy_q;
  assign bit_end = busy_q && (baud_cnt_q == baud_cnt_w'(clks_per_bit - 1));

  // ************************************************************
  // Line sequencing
  // ************************************************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q     <= 1'b0;
      tx         <= 1'b1;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end
    else if (tx_acc)
    begin
      // Start bit goes out right away.
      busy_q     <= 1'b1;
      tx         <= 1'b0;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end
    else if (bit_end)
    begin
      baud_cnt_q <= '0;
      if (bit_cnt_q == bit_cnt_w'(frame_bits - 1))
      begin
        busy_q <= 1'b0;
      end
      else
      begin
        tx        <= shift_q[0];
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
    else if (busy_q)
    begin
      baud_cnt_q <= baud_cnt_q + 1'b1;
    end
  end

  // Odd parity over the data byte.
  always_ff @(posedge clk)
  begin
    if (tx_acc)
    begin
      shift_q <= {1'b1, ~^tx_byte, tx_byte};
    end
    else if (bit_end)
    begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

`default_nettype wire

/* rtl/uart_cmd_pkg.sv */
`default_nettype none

package uart_cmd_pkg;

  // Write view of a host command.
  typedef struct packed {
    logic       is_wr;
    logic [6:0] addr;
    logic [7:0] data;
  } wr_cmd_t;

  // Read view, low byte carries nothing.
  typedef struct packed {
    logic       is_wr;
    logic [6:0] addr;
    logic [7:0] unused;
  } rd_cmd_t;

  // One 16-bit host word, decoded by its top bit.
  typedef union packed {
    wr_cmd_t wr;
    rd_cmd_t rd;
  } cmd_word_u;

  // Result of one received frame.
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       frame_err;
  } frame_byte_t;

  // Read response to the host.
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       timeout;
  } rsp_t;

endpackage

`default_nettype wire

/* rtl/uart_cfg_pkg.sv */
`default_nettype none

package uart_cfg_pkg;

  // ************************************************************
  // Line timing
  // ************************************************************

  // Clock cycles per serial bit.
  localparam int clks_per_bit = 8;

  // Mid-bit sample point after the start edge.
  localparam int half_bit = clks_per_bit / 2;

  // Payload bits, and the whole frame with start, parity and stop.
  localparam int data_bits  = 8;
  localparam int frame_bits = data_bits + 3;

  // Idle cycles between the two frames of one command.
  localparam int frame_gap = 100;

  // Wait for a response start bit, 40 bit periods.
  localparam int rsp_timeout = 40 * clks_per_bit;

  // ************************************************************
  // Counter widths
  // ************************************************************

  localparam int baud_cnt_w = $clog2(clks_per_bit);
  localparam int bit_cnt_w  = $clog2(frame_bits);
  localparam int wait_cnt_w = $clog2((rsp_timeout > frame_gap) ? rsp_timeout : frame_gap);

endpackage

`default_nettype wire
